//--- include/map_macros.svh
`ifndef MAP_MACROS_SVH
`define MAP_MACROS_SVH

// Control register indices in mmc_regs.
`define MAP_REG_CFG 0
`define MAP_REG_MIRROR 2
`define MAP_REG_RAM_CFG 3
`define MAP_REG_RELOAD 4

// Bank register values after reset.
`define MAP_BANK_RST0 8'd0
`define MAP_BANK_RST1 8'd2
`define MAP_BANK_RST2 8'd4
`define MAP_BANK_RST3 8'd5
`define MAP_BANK_RST4 8'd6
`define MAP_BANK_RST5 8'd7
`define MAP_BANK_RST6 8'd0
`define MAP_BANK_RST7 8'd1

// Mapper number returned by save state readback.
`define MAP_IDX 8'd118

// Low A12 samples needed before a rise is counted.
`define MAP_A12_FILT 8

`endif

//--- rtl/map_pkg.sv
`default_nettype none

package map_pkg;

	// Bank byte as used on TxSROM boards.
	typedef struct packed
	{
		logic nt_a10; // Drives CIRAM A10.
		logic [6:0] bank;
	} chr_txs_t;

	// One CHR bank byte seen as a plain bank or as the TxSROM split.
	typedef union packed
	{
		logic [7:0] raw;
		chr_txs_t txs;
	} chr_bank_u;

	// Eight byte register array.
	typedef logic [7:0][7:0] reg_file_t;

endpackage

`default_nettype wire

//--- rtl/map_cpu_if.sv
`timescale 1ns/10ps
`default_nettype none

interface map_cpu_if;

	logic [14:0] cpu_addr;
	logic [7:0] cpu_dat;
	logic cpu_ce; // Low for $8000-$FFFF.
	logic cpu_rw;

	// Save state access.
	logic ss_act;
	logic ss_we;
	logic [7:0] ss_addr;

	modport regs
	(
		input cpu_addr, cpu_dat, cpu_ce, cpu_rw,
		input ss_act, ss_we, ss_addr
	);

	modport irq
	(
		input cpu_dat,
		input ss_act, ss_we, ss_addr
	);

endinterface

`default_nettype wire

//--- rtl/txs_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "map_macros.svh"

module txs_regs import map_pkg::*;
(
	input logic m2,
	input logic map_rst,
	map_cpu_if.regs bus,
	output reg_file_t mmc_regs,
	output reg_file_t bank_regs,
	output logic reload_wr,
	output logic irq_dis,
	output logic irq_en
);

	logic [2:0] reg_idx;
	logic [2:0] bank_sel;
	logic cpu_wr;
	logic ss_wr;

	assign reg_idx = {bus.cpu_addr[14], bus.cpu_addr[13], bus.cpu_addr[0]};
	assign bank_sel = mmc_regs[`MAP_REG_CFG][2:0];

	// Store to $8000-$FFFF outside of a save state cycle.
	assign cpu_wr = !bus.cpu_ce & !bus.cpu_rw & !bus.ss_act;
	assign ss_wr = bus.ss_act & bus.ss_we;

	// IRQ strobes act on the same edge as the register write.
	assign reload_wr = cpu_wr & (reg_idx == 3'd5);
	assign irq_dis = cpu_wr & (reg_idx == 3'd6);
	assign irq_en = cpu_wr & (reg_idx == 3'd7);

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			mmc_regs[`MAP_REG_CFG] <= 8'd0;
			mmc_regs[`MAP_REG_MIRROR] <= 8'd0;
			mmc_regs[`MAP_REG_RAM_CFG] <= 8'd0; // RAM off, writable.
		end
		else if (ss_wr)
		begin
			if (bus.ss_addr[7:3] == 5'd0)
				mmc_regs[bus.ss_addr[2:0]] <= bus.cpu_dat;
		end
		else if (cpu_wr)
		begin
			mmc_regs[reg_idx] <= bus.cpu_dat;
		end
	end

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			bank_regs[0] <= `MAP_BANK_RST0;
			bank_regs[1] <= `MAP_BANK_RST1;
			bank_regs[2] <= `MAP_BANK_RST2;
			bank_regs[3] <= `MAP_BANK_RST3;
			bank_regs[4] <= `MAP_BANK_RST4;
			bank_regs[5] <= `MAP_BANK_RST5;
			bank_regs[6] <= `MAP_BANK_RST6;
			bank_regs[7] <= `MAP_BANK_RST7;
		end
		else if (ss_wr)
		begin
			if (bus.ss_addr[7:3] == 5'd1)
				bank_regs[bus.ss_addr[2:0]] <= bus.cpu_dat;
		end
		else if (cpu_wr & (reg_idx == 3'd1))
		begin
			bank_regs[bank_sel] <= bus.cpu_dat; // Bank data port.
		end
	end

endmodule

`default_nettype wire

//--- rtl/txs_scanline_irq.sv
`timescale 1ns/10ps
`default_nettype none

`include "map_macros.svh"

module txs_scanline_irq
(
	input logic m2,
	input logic map_rst,
	map_cpu_if.irq bus,
	input logic a12,
	input logic cfg_mmc3b,
	input logic [7:0] reload_val,
	input logic reload_wr,
	input logic irq_dis,
	input logic irq_en,
	output logic [7:0] irq_ctr,
	output logic irq_on,
	output logic irq_pend,
	output logic irq_reload_req,
	output logic irq_act
);

	logic [`MAP_A12_FILT-1:0] a12_filt; // Recent A12 samples.
	logic a12_rise;
	logic irq_reload;

	// A rise only counts after a full run of low samples.
	assign a12_rise = a12 & (a12_filt == '0) & !bus.ss_act;

	// Rev B parts also reload whenever the counter sits at zero.
	assign irq_reload = irq_reload_req | (cfg_mmc3b & (irq_ctr == 8'd0));

	assign irq_act = irq_on & a12_rise &
		((!irq_reload & (irq_ctr == 8'd1)) | (irq_reload & (reload_val == 8'd0)));

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			a12_filt <= '1;
			irq_ctr <= 8'd0;
			irq_on <= 1'b0;
			irq_pend <= 1'b0;
			irq_reload_req <= 1'b0;
		end
		else if (bus.ss_act)
		begin
			if (bus.ss_we & (bus.ss_addr == 8'd16))
				irq_ctr <= bus.cpu_dat;
			if (bus.ss_we & (bus.ss_addr == 8'd17))
			begin
				irq_on <= bus.cpu_dat[5] ^ bus.cpu_dat[4];
				irq_pend <= bus.cpu_dat[3] ^ bus.cpu_dat[2];
				irq_reload_req <= bus.cpu_dat[1] ^ bus.cpu_dat[0];
			end
		end
		else
		begin
			a12_filt <= {a12_filt[`MAP_A12_FILT-2:0], a12};
			if (a12_rise)
			begin
				if (irq_reload | (irq_ctr == 8'd0))
					irq_ctr <= reload_val;
				else
					irq_ctr <= irq_ctr - 8'd1;
				if (irq_reload)
					irq_reload_req <= 1'b0;
				if (irq_act)
					irq_pend <= 1'b1;
			end
			// CPU writes win over the counter.
			if (reload_wr)
				irq_reload_req <= 1'b1;
			if (irq_dis)
			begin
				irq_on <= 1'b0;
				irq_pend <= 1'b0; // Acknowledge.
			end
			if (irq_en)
				irq_on <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/txs_addr_combine.sv
`timescale 1ns/10ps
`default_nettype none

`include "map_macros.svh"

module txs_addr_combine import map_pkg::*;
(
	input logic [14:0] cpu_addr,
	input logic cpu_ce,
	input logic cpu_rw,
	input logic [13:0] ppu_addr,
	input logic ppu_we,
	input logic cfg_chr_ram,
	input logic [7:0] ss_addr,
	input reg_file_t mmc_regs,
	input reg_file_t bank_regs,
	input logic [7:0] irq_ctr,
	input logic irq_on,
	input logic irq_pend,
	input logic irq_reload_req,
	input logic irq_act,
	output logic [18:0] prg_addr,
	output logic [17:0] chr_addr,
	output logic ciram_a10,
	output logic ciram_ce,
	output logic chr_ce,
	output logic chr_we,
	output logic rom_ce,
	output logic ram_ce,
	output logic ram_we,
	output logic map_cpu_oe,
	output logic irq,
	output logic [7:0] ss_rdat
);

	logic swap_control;
	logic chr_invert;
	logic ram_on;
	logic ram_we_off;
	logic ram_area;
	logic [5:0] prg_bank;
	chr_bank_u chr_sel;

	assign swap_control = mmc_regs[`MAP_REG_CFG][6];
	assign chr_invert = mmc_regs[`MAP_REG_CFG][7];
	assign ram_on = mmc_regs[`MAP_REG_RAM_CFG][7];
	assign ram_we_off = mmc_regs[`MAP_REG_RAM_CFG][6];

	// 8 KB PRG windows.
	always_comb
	begin
		case (cpu_addr[14:13])
			2'd0: prg_bank = swap_control ? 6'h3e : bank_regs[6][5:0];
			2'd1: prg_bank = bank_regs[7][5:0];
			2'd2: prg_bank = swap_control ? bank_regs[6][5:0] : 6'h3e;
			default: prg_bank = 6'h3f;
		endcase
	end

	assign prg_addr = {(cpu_ce ? 6'd0 : prg_bank), cpu_addr[12:0]};
	assign rom_ce = !cpu_ce;

	// PRG RAM at $6000-$7FFF.
	assign ram_area = (cpu_addr[14:13] == 2'b11) & cpu_ce;
	assign ram_ce = ram_area & ram_on;
	assign ram_we = ram_ce & !cpu_rw & !ram_we_off;
	assign map_cpu_oe = ram_area & !ram_on & cpu_rw; // Open bus.

	// Two 2 KB and four 1 KB CHR windows. Invert swaps the halves.
	always_comb
	begin
		if (ppu_addr[12:11] == {chr_invert, 1'b0})
			chr_sel.raw = {bank_regs[0][7:1], ppu_addr[10]};
		else if (ppu_addr[12:11] == {chr_invert, 1'b1})
			chr_sel.raw = {bank_regs[1][7:1], ppu_addr[10]};
		else
		begin
			case (ppu_addr[11:10])
				2'd0: chr_sel.raw = bank_regs[2];
				2'd1: chr_sel.raw = bank_regs[3];
				2'd2: chr_sel.raw = bank_regs[4];
				default: chr_sel.raw = bank_regs[5];
			endcase
		end
	end

	assign chr_addr[17:10] = cfg_chr_ram ? {5'd0, chr_sel.raw[2:0]} : chr_sel.raw;
	assign chr_addr[9:0] = ppu_addr[9:0];
	assign ciram_a10 = chr_sel.txs.nt_a10; // Nametable select from bank bit 7.

	assign ciram_ce = !ppu_addr[13];
	assign chr_ce = !ppu_addr[13];
	assign chr_we = cfg_chr_ram & chr_ce & !ppu_we;

	assign irq = irq_pend | irq_act;

	always_comb
	begin
		if (ss_addr[7:3] == 5'd0)
			ss_rdat = mmc_regs[ss_addr[2:0]];
		else if (ss_addr[7:3] == 5'd1)
			ss_rdat = bank_regs[ss_addr[2:0]];
		else if (ss_addr == 8'd16)
			ss_rdat = irq_ctr;
		else if (ss_addr == 8'd17)
			ss_rdat = {3'b000, irq_on, irq_pend, 1'b0, irq_reload_req, 1'b0};
		else if (ss_addr == 8'd127)
			ss_rdat = `MAP_IDX;
		else
			ss_rdat = 8'hff;
	end

endmodule

`default_nettype wire

//--- rtl/map_118.sv
`timescale 1ns/10ps
`default_nettype none

`include "map_macros.svh"

module map_118 import map_pkg::*;
(
	input logic m2,
	input logic map_rst,
	input logic [14:0] cpu_addr,
	input logic [7:0] cpu_dat,
	input logic cpu_ce,
	input logic cpu_rw,
	input logic [13:0] ppu_addr,
	input logic ppu_we,
	input logic ss_act,
	input logic ss_we,
	input logic [7:0] ss_addr,
	input logic cfg_chr_ram,
	input logic cfg_mmc3b,
	output logic [18:0] prg_addr,
	output logic [17:0] chr_addr,
	output logic ciram_a10,
	output logic ciram_ce,
	output logic chr_ce,
	output logic chr_we,
	output logic rom_ce,
	output logic ram_ce,
	output logic ram_we,
	output logic map_cpu_oe,
	output logic irq,
	output logic [7:0] ss_rdat
);

	reg_file_t mmc_regs;
	reg_file_t bank_regs;
	logic reload_wr;
	logic irq_dis;
	logic irq_en;
	logic [7:0] irq_ctr;
	logic irq_on;
	logic irq_pend;
	logic irq_reload_req;
	logic irq_act;

	map_cpu_if cpu_bus();

	assign cpu_bus.cpu_addr = cpu_addr;
	assign cpu_bus.cpu_dat = cpu_dat;
	assign cpu_bus.cpu_ce = cpu_ce;
	assign cpu_bus.cpu_rw = cpu_rw;
	assign cpu_bus.ss_act = ss_act;
	assign cpu_bus.ss_we = ss_we;
	assign cpu_bus.ss_addr = ss_addr;

	txs_regs i_regs
	(
		.m2(m2),
		.map_rst(map_rst),
		.bus(cpu_bus.regs),
		.mmc_regs(mmc_regs),
		.bank_regs(bank_regs),
		.reload_wr(reload_wr),
		.irq_dis(irq_dis),
		.irq_en(irq_en)
	);

	txs_scanline_irq i_irq
	(
		.m2(m2),
		.map_rst(map_rst),
		.bus(cpu_bus.irq),
		.a12(ppu_addr[12]),
		.cfg_mmc3b(cfg_mmc3b),
		.reload_val(mmc_regs[`MAP_REG_RELOAD]),
		.reload_wr(reload_wr),
		.irq_dis(irq_dis),
		.irq_en(irq_en),
		.irq_ctr(irq_ctr),
		.irq_on(irq_on),
		.irq_pend(irq_pend),
		.irq_reload_req(irq_reload_req),
		.irq_act(irq_act)
	);

	txs_addr_combine i_addr
	(
		.cpu_addr(cpu_addr),
		.cpu_ce(cpu_ce),
		.cpu_rw(cpu_rw),
		.ppu_addr(ppu_addr),
		.ppu_we(ppu_we),
		.cfg_chr_ram(cfg_chr_ram),
		.ss_addr(ss_addr),
		.mmc_regs(mmc_regs),
		.bank_regs(bank_regs),
		.irq_ctr(irq_ctr),
		.irq_on(irq_on),
		.irq_pend(irq_pend),
		.irq_reload_req(irq_reload_req),
		.irq_act(irq_act),
		.prg_addr(prg_addr),
		.chr_addr(chr_addr),
		.ciram_a10(ciram_a10),
		.ciram_ce(ciram_ce),
		.chr_ce(chr_ce),
		.chr_we(chr_we),
		.rom_ce(rom_ce),
		.ram_ce(ram_ce),
		.ram_we(ram_we),
		.map_cpu_oe(map_cpu_oe),
		.irq(irq),
		.ss_rdat(ss_rdat)
	);

endmodule

`default_nettype wire

//--- tb/map_118_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module map_118_asserts
(
	input logic m2,
	input logic map_rst,
	input logic irq,
	input logic ram_ce,
	input logic ram_we,
	input logic ciram_ce,
	input logic [13:0] ppu_addr
);

	// First reset edge clears the flags, so check from the second one.
	irq_low_in_reset: assert property (@(posedge m2) map_rst && $past(map_rst) |-> !irq)
		else $error("irq active during reset");

	ram_we_needs_ce: assert property (@(posedge m2) $rose(ram_we) |-> ram_ce)
		else $error("ram_we rose while ram_ce low");

	ciram_ce_decode: assert property (@(posedge m2) ciram_ce == !ppu_addr[13])
		else $error("ciram_ce does not follow ppu_addr[13]");

endmodule

bind map_118 map_118_asserts i_asserts
(
	.m2(m2),
	.map_rst(map_rst),
	.irq(irq),
	.ram_ce(ram_ce),
	.ram_we(ram_we),
	.ciram_ce(ciram_ce),
	.ppu_addr(ppu_addr)
);

`default_nettype wire

//--- tb/tb_map_118.sv
`timescale 1ns/10ps
`default_nettype none

`include "map_macros.svh"

module tb_map_118;

	logic m2 = 1'b0;
	logic map_rst;
	logic [14:0] cpu_addr;
	logic [7:0] cpu_dat;
	logic cpu_ce, cpu_rw;
	logic [13:0] ppu_addr;
	logic ppu_we;
	logic ss_act, ss_we;
	logic [7:0] ss_addr;
	logic cfg_chr_ram, cfg_mmc3b;
	logic [18:0] prg_addr;
	logic [17:0] chr_addr;
	logic ciram_a10, ciram_ce, chr_ce, chr_we, rom_ce;
	logic ram_ce, ram_we, map_cpu_oe, irq;
	logic [7:0] ss_rdat;

	integer seed = 32'h49248f90;
	integer err_count = 0;
	integer i, j, k, n, cnt;
	logic [7:0] mmc_sh [8]; // Shadow registers.
	logic [7:0] bank_sh [8];
	logic [7:0] m_ctr;
	logic m_on, m_pend, m_rreq;

	map_118 i_map_118 (.*);

	always #2 m2 = !m2;

	initial
	begin
		#200000;
		$display("Simulation timed out");
		$display("Test FAILED");
		$fatal(1);
	end

	function automatic logic [18:0] ref_prg_addr(input logic [14:0] a);
		logic [5:0] win [4];
		win[0] = mmc_sh[0][6] ? 6'h3e : bank_sh[6][5:0];
		win[1] = bank_sh[7][5:0];
		win[2] = mmc_sh[0][6] ? bank_sh[6][5:0] : 6'h3e;
		win[3] = 6'h3f;
		return {win[a[14:13]], a[12:0]};
	endfunction

	// Bank byte of the 1 KB window that a PPU address falls in.
	function automatic logic [7:0] chr_bank_of(input logic [13:0] a);
		logic [2:0] w;
		w = a[12:10] ^ {mmc_sh[0][7], 2'b00};
		if (w < 4)
			return {bank_sh[w >> 1][7:1], w[0]};
		return bank_sh[w - 2];
	endfunction

	function automatic logic [17:0] ref_chr_addr(input logic [13:0] a);
		logic [7:0] b;
		b = chr_bank_of(a);
		if (cfg_chr_ram)
			b = {5'd0, b[2:0]}; // 8 KB of CHR RAM.
		return {b, a[9:0]};
	endfunction

	function automatic logic ref_ciram_a10(input logic [13:0] a);
		logic [7:0] b;
		b = chr_bank_of(a);
		return b[7];
	endfunction

	function automatic logic [7:0] ref_ss_rdat(input logic [7:0] a);
		if (a < 8)
			return mmc_sh[a];
		if (a < 16)
			return bank_sh[a - 8];
		if (a == 16)
			return m_ctr;
		if (a == 17)
			return {3'b000, m_on, m_pend, 1'b0, m_rreq, 1'b0};
		if (a == 127)
			return `MAP_IDX;
		return 8'hff;
	endfunction

	task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp);
		if (act !== exp)
		begin
			err_count = err_count + 1;
			$display("ERR %s actual=%h expected=%h", name, act, exp);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic cpu_write(input logic [2:0] idx, input logic [7:0] dat);
		@(negedge m2);
		cpu_ce = 1'b0;
		cpu_rw = 1'b0;
		cpu_addr = {idx[2], idx[1], 12'h000, idx[0]};
		cpu_dat = dat;
		@(posedge m2);
		if (idx == 1)
			bank_sh[mmc_sh[0][2:0]] = dat;
		mmc_sh[idx] = dat;
		if (idx == 5)
			m_rreq = 1'b1;
		if (idx == 6)
		begin
			m_on = 1'b0;
			m_pend = 1'b0;
		end
		if (idx == 7)
			m_on = 1'b1;
		@(negedge m2);
		cpu_ce = 1'b1;
		cpu_rw = 1'b1;
	endtask

	task automatic check_maps;
		for (k = 0; k < 4; k++)
		begin
			@(negedge m2);
			cpu_ce = 1'b0;
			cpu_addr = {k[1:0], 13'($random(seed))};
			#1 check("prg_addr", prg_addr, ref_prg_addr(cpu_addr));
			check("rom_ce", rom_ce, 1'b1);
		end
		@(negedge m2);
		cpu_ce = 1'b1;
		for (k = 0; k < 16; k++)
		begin
			@(negedge m2);
			ppu_addr = {k[3], k[2:0], 10'($random(seed))};
			ppu_we = k[0];
			#1;
			if (!ppu_addr[13])
				check("chr_addr", chr_addr, ref_chr_addr(ppu_addr));
			check("ciram_a10", ciram_a10, ref_ciram_a10(ppu_addr));
			check("ciram_ce", ciram_ce, !ppu_addr[13]);
			check("chr_ce", chr_ce, !ppu_addr[13]);
			check("chr_we", chr_we, cfg_chr_ram & !ppu_addr[13] & !ppu_we);
		end
		@(negedge m2);
		ppu_addr = 14'd0;
		ppu_we = 1'b1;
	endtask

	// Scanline counter step on a filtered A12 rise.
	task automatic ref_a12_edge;
		logic rl;
		logic [7:0] nxt;
		rl = m_rreq | (cfg_mmc3b & (m_ctr == 0));
		if (rl | (m_ctr == 0))
			nxt = mmc_sh[4];
		else
			nxt = m_ctr - 8'd1;
		// Zero reached by a count down or by a forced reload.
		if (m_on & (nxt == 0) & (rl | (m_ctr != 0)))
			m_pend = 1'b1;
		if (rl)
			m_rreq = 1'b0;
		m_ctr = nxt;
	endtask

	// A12 is low on entry, so the low run is exactly low_n samples.
	task automatic a12_pulse(input integer low_n);
		repeat (low_n) @(negedge m2);
		ppu_addr[12] = 1'b1;
		@(negedge m2);
		ppu_addr[12] = 1'b0;
		if (low_n >= `MAP_A12_FILT)
			ref_a12_edge();
		#1 check("irq", irq, m_pend);
	endtask

	task automatic ss_write(input logic [7:0] a, input logic [7:0] d);
		@(negedge m2);
		ss_act = 1'b1;
		ss_we = 1'b1;
		ss_addr = a;
		cpu_dat = d;
		@(posedge m2);
		if (a < 8)
			mmc_sh[a] = d;
		else if (a < 16)
			bank_sh[a - 8] = d;
		else if (a == 16)
			m_ctr = d;
		else
		begin
			m_on = d[5] ^ d[4];
			m_pend = d[3] ^ d[2];
			m_rreq = d[1] ^ d[0];
		end
		@(negedge m2);
		ss_we = 1'b0;
		ss_act = 1'b0;
	endtask

	task automatic ss_read_all;
		for (k = 0; k < 19; k++)
		begin
			@(negedge m2);
			ss_act = 1'b1;
			ss_addr = (k == 18) ? 8'd127 : 8'(k);
			#1 check("ss_rdat", ss_rdat, ref_ss_rdat(ss_addr));
		end
		@(negedge m2);
		ss_act = 1'b0;
	endtask

	initial
	begin
		map_rst = 1'b1;
		cpu_addr = '0;
		cpu_dat = '0;
		cpu_ce = 1'b1;
		cpu_rw = 1'b1;
		ppu_addr = '0;
		ppu_we = 1'b1;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = '0;
		cfg_chr_ram = 1'b0;
		cfg_mmc3b = 1'b0;
		mmc_sh = '{default: 8'd0};
		bank_sh = '{`MAP_BANK_RST0, `MAP_BANK_RST1, `MAP_BANK_RST2, `MAP_BANK_RST3,
			`MAP_BANK_RST4, `MAP_BANK_RST5, `MAP_BANK_RST6, `MAP_BANK_RST7};
		m_ctr = 8'd0;
		m_on = 1'b0;
		m_pend = 1'b0;
		m_rreq = 1'b0;
		repeat (16) @(posedge m2);
		@(negedge m2);
		map_rst = 1'b0;

		#1 check("irq", irq, 1'b0);
		check("ram_we", ram_we, 1'b0);
		check_maps();

		// Random banks in every swap and invert mode.
		for (i = 0; i < 4; i++)
		begin
			for (j = 0; j < 8; j++)
			begin
				cpu_write(3'd0, {i[1], i[0], 3'b000, j[2:0]});
				cpu_write(3'd1, 8'($random(seed)));
			end
			check_maps();
		end

		// CHR RAM keeps three bank bits.
		@(negedge m2);
		cfg_chr_ram = 1'b1;
		check_maps();
		@(negedge m2);
		cfg_chr_ram = 1'b0;

		// PRG RAM enable and protect.
		for (i = 0; i < 4; i++)
		begin
			cpu_write(3'd3, {i[1], i[0], 6'd0});
			for (j = 0; j < 2; j++)
			begin
				@(negedge m2);
				cpu_addr = {2'b11, 13'($random(seed))};
				cpu_rw = j[0];
				#1 check("ram_ce", ram_ce, i[1]);
				check("ram_we", ram_we, i[1] & !i[0] & !j[0]);
				check("map_cpu_oe", map_cpu_oe, !i[1] & j[0]);
				check("rom_ce", rom_ce, 1'b0);
			end
			@(negedge m2);
			cpu_rw = 1'b1;
		end

		// Scanline IRQ after N+1 filtered rises.
		n = 1 + ($unsigned($random(seed)) % 5);
		cpu_write(3'd4, 8'(n));
		cpu_write(3'd5, 8'd0);
		cpu_write(3'd7, 8'd0);
		cnt = 0;
		while (!irq)
		begin
			a12_pulse(`MAP_A12_FILT);
			a12_pulse(`MAP_A12_FILT - 1); // One sample short of the filter.
			cnt = cnt + 1;
			if (cnt > 20)
			begin
				$display("irq never rose after %0d A12 rises", cnt);
				$display("Test FAILED");
				$fatal(1);
			end
		end
		check("irq_edges", cnt, n + 1);
		cpu_write(3'd6, 8'd0);
		#1 check("irq", irq, 1'b0);

		// Rev B with a zero reload fires on every rise.
		@(negedge m2);
		cfg_mmc3b = 1'b1;
		cpu_write(3'd4, 8'd0);
		cpu_write(3'd5, 8'd0);
		for (i = 0; i < 3; i++)
		begin
			cpu_write(3'd7, 8'd0);
			a12_pulse(`MAP_A12_FILT + 2);
			check("irq", irq, 1'b1);
			cpu_write(3'd6, 8'd0);
		end
		cfg_mmc3b = 1'b0;

		// Save state readback, then restore and read again.
		ss_read_all();
		for (i = 0; i < 18; i++)
			ss_write(8'(i), 8'($random(seed)));
		ss_read_all();

		if (err_count == 0)
		begin
			$display("Test OK");
			$finish;
		end
		else
		begin
			$display("Test FAILED");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
rtl/map_pkg.sv
rtl/map_cpu_if.sv
rtl/txs_regs.sv
rtl/txs_scanline_irq.sv
rtl/txs_addr_combine.sv
rtl/map_118.sv
tb/map_118_asserts.sv
tb/tb_map_118.sv

//--- Bender.yml
package:
  name: map_118

sources:
  - include_dirs:
      - include
    files:
      - rtl/map_pkg.sv
      - rtl/map_cpu_if.sv
      - rtl/txs_regs.sv
      - rtl/txs_scanline_irq.sv
      - rtl/txs_addr_combine.sv
      - rtl/map_118.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/map_118_asserts.sv
      - tb/tb_map_118.sv
